// File: common/axi2iob_defines.svh
/*
 * Bus field widths for the AXI4 to IOb adapter.
 * Included by the package, which builds its field types from them.
 */
`ifndef AXI2IOB_DEFINES_SVH
`define AXI2IOB_DEFINES_SVH

// address and data buses
`define AXI2IOB_ADDR_W 32
`define AXI2IOB_DATA_W 32

// AXI4 burst fields
`define AXI2IOB_ID_W   8
`define AXI2IOB_LEN_W  8
`define AXI2IOB_SIZE_W 3

`endif

// File: common/axi2iob_pkg.sv
/*
 * Field types shared by the burst splitters, the IOb bridge and the
 * single-beat request interface. Also holds the splitter state type.
 */
`default_nettype none

`include "axi2iob_defines.svh"

package axi2iob_pkg;

   typedef logic [`AXI2IOB_ADDR_W-1:0]   addr_t;
   typedef logic [`AXI2IOB_DATA_W-1:0]   data_t;
   // one strobe bit per data byte
   typedef logic [`AXI2IOB_DATA_W/8-1:0] strb_t;
   typedef logic [`AXI2IOB_ID_W-1:0]     id_t;
   // beats in the burst minus one
   typedef logic [`AXI2IOB_LEN_W-1:0]    len_t;
   // log2 of bytes per beat
   typedef logic [`AXI2IOB_SIZE_W-1:0]   size_t;

   // read splitter never enters st_resp
   typedef enum logic [1:0] {
      st_idle = 2'd0,
      st_data = 2'd1,
      st_resp = 2'd2
   } burst_state_t;

endpackage

`default_nettype wire

// File: common/axil_if.sv
/*
 * Single-beat request channel from a burst splitter to the IOb bridge.
 * The splitter takes the mgr side, the bridge the sub side.
 */
`timescale 1ns/1ps
`default_nettype none

interface axil_if;
   import axi2iob_pkg::*;

   // request, held stable until accepted
   logic  req_valid;
   addr_t req_addr;
   data_t req_wdata;
   strb_t req_wstrb;
   logic  req_ready;

   // read data, a one-cycle pulse per accepted read
   logic  rsp_valid;
   data_t rsp_rdata;

   modport mgr (
      output req_valid,
      output req_addr,
      output req_wdata,
      output req_wstrb,
      input  req_ready,
      input  rsp_valid,
      input  rsp_rdata
   );

   modport sub (
      input  req_valid,
      input  req_addr,
      input  req_wdata,
      input  req_wstrb,
      output req_ready,
      output rsp_valid,
      output rsp_rdata
   );

endinterface

`default_nettype wire

// File: burst/axi_wr_splitter.sv
/*
 * Splits an AXI4 write burst into single-beat write requests, one per
 * W beat, and answers the burst with one B response.
 */
`timescale 1ns/1ps
`default_nettype none

module axi_wr_splitter (
   input  wire                       clk_i,
   input  wire                       arst_i,
   input  wire axi2iob_pkg::id_t     s_axi_awid_i,
   input  wire axi2iob_pkg::addr_t   s_axi_awaddr_i,
   input  wire axi2iob_pkg::len_t    s_axi_awlen_i,
   input  wire axi2iob_pkg::size_t   s_axi_awsize_i,
   input  wire                       s_axi_awvalid_i,
   output logic                      s_axi_awready_o,
   input  wire axi2iob_pkg::data_t   s_axi_wdata_i,
   input  wire axi2iob_pkg::strb_t   s_axi_wstrb_i,
   input  wire                       s_axi_wvalid_i,
   output logic                      s_axi_wready_o,
   output axi2iob_pkg::id_t          s_axi_bid_o,
   output logic                      s_axi_bvalid_o,
   input  wire                       s_axi_bready_i,
   axil_if.mgr                       wr_bus
);
   import axi2iob_pkg::*;

   burst_state_t state_q;
   id_t          id_q;
   addr_t        addr_q;
   len_t         cnt_q;
   size_t        size_q;
   data_t        wdata_q;
   strb_t        wstrb_q;
   logic         req_valid_q;
   logic         aw_hs;
   logic         w_hs;
   logic         req_hs;

   assign aw_hs  = s_axi_awready_o & s_axi_awvalid_i;
   assign w_hs   = s_axi_wready_o & s_axi_wvalid_i;
   assign req_hs = req_valid_q & wr_bus.req_ready;

   assign wr_bus.req_valid = req_valid_q;
   assign wr_bus.req_addr  = addr_q;
   assign wr_bus.req_wdata = wdata_q;
   assign wr_bus.req_wstrb = wstrb_q;

   // id stays put until the next AW, which waits for B to be taken
   assign s_axi_bid_o = id_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q         <= st_idle;
         s_axi_awready_o <= 1'b0;
         s_axi_wready_o  <= 1'b0;
         s_axi_bvalid_o  <= 1'b0;
         req_valid_q     <= 1'b0;
      end else begin
         case (state_q)
            st_idle: begin
               if (aw_hs) begin
                  s_axi_awready_o <= 1'b0;
                  s_axi_wready_o  <= 1'b1;
                  state_q         <= st_data;
               end else begin
                  s_axi_awready_o <= 1'b1;
               end
            end
            st_data: begin
               // one beat at a time, W is closed while the request is open
               if (w_hs) begin
                  s_axi_wready_o <= 1'b0;
                  req_valid_q    <= 1'b1;
               end else if (req_hs) begin
                  req_valid_q <= 1'b0;
                  if (cnt_q == '0) begin
                     s_axi_bvalid_o <= 1'b1;
                     state_q        <= st_resp;
                  end else begin
                     s_axi_wready_o <= 1'b1;
                  end
               end
            end
            st_resp: begin
               if (s_axi_bvalid_o && s_axi_bready_i) begin
                  s_axi_bvalid_o <= 1'b0;
                  state_q        <= st_idle;
               end
            end
            default: state_q <= st_idle;
         endcase
      end
   end

   // burst context and beat payload
   always_ff @(posedge clk_i) begin
      if (aw_hs) begin
         id_q   <= s_axi_awid_i;
         addr_q <= s_axi_awaddr_i;
         cnt_q  <= s_axi_awlen_i;
         size_q <= s_axi_awsize_i;
      end
      if (w_hs) begin
         wdata_q <= s_axi_wdata_i;
         wstrb_q <= s_axi_wstrb_i;
      end
      // incrementing burst only
      if (req_hs) begin
         addr_q <= addr_q + (addr_t'(1) << size_q);
         cnt_q  <= cnt_q - len_t'(1);
      end
   end

endmodule

`default_nettype wire

// File: burst/axi_rd_splitter.sv
/*
 * Splits an AXI4 read burst into single-beat read requests and returns
 * each response as one R beat, with rlast on the final one.
 */
`timescale 1ns/1ps
`default_nettype none

module axi_rd_splitter (
   input  wire                       clk_i,
   input  wire                       arst_i,
   input  wire axi2iob_pkg::id_t     s_axi_arid_i,
   input  wire axi2iob_pkg::addr_t   s_axi_araddr_i,
   input  wire axi2iob_pkg::len_t    s_axi_arlen_i,
   input  wire axi2iob_pkg::size_t   s_axi_arsize_i,
   input  wire                       s_axi_arvalid_i,
   output logic                      s_axi_arready_o,
   output axi2iob_pkg::id_t          s_axi_rid_o,
   output axi2iob_pkg::data_t        s_axi_rdata_o,
   output logic                      s_axi_rlast_o,
   output logic                      s_axi_rvalid_o,
   input  wire                       s_axi_rready_i,
   axil_if.mgr                       rd_bus
);
   import axi2iob_pkg::*;

   burst_state_t state_q;
   id_t          id_q;
   addr_t        addr_q;
   len_t         cnt_q;
   size_t        size_q;
   logic         last_q;
   logic         req_valid_q;
   logic         ar_hs;
   logic         req_hs;
   logic         r_hs;

   assign ar_hs  = s_axi_arready_o & s_axi_arvalid_i;
   assign req_hs = req_valid_q & rd_bus.req_ready;
   assign r_hs   = s_axi_rvalid_o & s_axi_rready_i;

   assign rd_bus.req_valid = req_valid_q;
   assign rd_bus.req_addr  = addr_q;
   assign rd_bus.req_wdata = '0;
   assign rd_bus.req_wstrb = '0;

   assign s_axi_rid_o   = id_q;
   // registered together with rvalid, cleared when the beat is taken
   assign s_axi_rlast_o = last_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q         <= st_idle;
         s_axi_arready_o <= 1'b0;
         s_axi_rvalid_o  <= 1'b0;
         last_q          <= 1'b0;
         req_valid_q     <= 1'b0;
      end else begin
         case (state_q)
            st_idle: begin
               if (ar_hs) begin
                  s_axi_arready_o <= 1'b0;
                  req_valid_q     <= 1'b1;
                  state_q         <= st_data;
               end else begin
                  s_axi_arready_o <= 1'b1;
               end
            end
            st_data: begin
               if (req_hs) begin
                  req_valid_q <= 1'b0;
               end
               // R slot is empty whenever a response can arrive
               if (rd_bus.rsp_valid) begin
                  s_axi_rvalid_o <= 1'b1;
                  last_q         <= (cnt_q == '0);
               end
               if (r_hs) begin
                  s_axi_rvalid_o <= 1'b0;
                  last_q         <= 1'b0;
                  if (last_q) begin
                     state_q <= st_idle;
                  end else begin
                     req_valid_q <= 1'b1;
                  end
               end
            end
            default: state_q <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (ar_hs) begin
         id_q   <= s_axi_arid_i;
         addr_q <= s_axi_araddr_i;
         cnt_q  <= s_axi_arlen_i;
         size_q <= s_axi_arsize_i;
      end
      if (req_hs) begin
         addr_q <= addr_q + (addr_t'(1) << size_q);
      end
      if (rd_bus.rsp_valid) begin
         s_axi_rdata_o <= rd_bus.rsp_rdata;
         cnt_q         <= cnt_q - len_t'(1);
      end
   end

endmodule

`default_nettype wire

// File: src/axil2iob_bridge.sv
/*
 * Merges the write and read request streams onto one IOb manager port.
 * Reads win, and only one read may be outstanding on the IOb bus.
 */
`timescale 1ns/1ps
`default_nettype none

module axil2iob_bridge (
   input  wire                       clk_i,
   input  wire                       arst_i,
   axil_if.sub                       wr_bus,
   axil_if.sub                       rd_bus,
   output logic                      iob_valid_o,
   output axi2iob_pkg::addr_t        iob_addr_o,
   output axi2iob_pkg::data_t        iob_wdata_o,
   output axi2iob_pkg::strb_t        iob_wstrb_o,
   input  wire                       iob_ready_i,
   input  wire                       iob_rvalid_i,
   input  wire axi2iob_pkg::data_t   iob_rdata_i
);

   logic rd_pend_q;
   logic wr_has_strb;
   logic rd_go;
   logic wr_go;

   assign wr_has_strb = |wr_bus.req_wstrb;

   // nothing new goes out until the pending read returns
   assign rd_go = rd_bus.req_valid & ~rd_pend_q;
   assign wr_go = wr_bus.req_valid & ~rd_bus.req_valid & ~rd_pend_q;

   // write with no strobes set never reaches the bus
   assign iob_valid_o = rd_go | (wr_go & wr_has_strb);
   assign iob_addr_o  = rd_bus.req_valid ? rd_bus.req_addr : wr_bus.req_addr;
   assign iob_wdata_o = wr_bus.req_wdata;
   assign iob_wstrb_o = rd_bus.req_valid ? '0 : wr_bus.req_wstrb;

   assign rd_bus.req_ready = ~rd_pend_q & iob_ready_i;
   assign wr_bus.req_ready = ~rd_pend_q & ~rd_bus.req_valid & (iob_ready_i | ~wr_has_strb);

   // read data is passed straight through
   assign rd_bus.rsp_valid = rd_pend_q & iob_rvalid_i;
   assign rd_bus.rsp_rdata = iob_rdata_i;

   // writes complete on acceptance
   assign wr_bus.rsp_valid = 1'b0;
   assign wr_bus.rsp_rdata = '0;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         rd_pend_q <= 1'b0;
      end else if (rd_go && iob_ready_i) begin
         rd_pend_q <= 1'b1;
      end else if (iob_rvalid_i) begin
         rd_pend_q <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: src/axi2iob_top.sv
/*
 * AXI4 subordinate to IOb manager adapter, top level.
 * Bursts are split per beat and forwarded one IOb access at a time.
 */
`timescale 1ns/1ps
`default_nettype none

module axi2iob_top (
   input  wire                       clk_i,
   input  wire                       arst_i,

   // AXI4 write channels
   input  wire axi2iob_pkg::id_t     s_axi_awid_i,
   input  wire axi2iob_pkg::addr_t   s_axi_awaddr_i,
   input  wire axi2iob_pkg::len_t    s_axi_awlen_i,
   input  wire axi2iob_pkg::size_t   s_axi_awsize_i,
   input  wire                       s_axi_awvalid_i,
   output logic                      s_axi_awready_o,
   input  wire axi2iob_pkg::data_t   s_axi_wdata_i,
   input  wire axi2iob_pkg::strb_t   s_axi_wstrb_i,
   input  wire                       s_axi_wvalid_i,
   output logic                      s_axi_wready_o,
   output axi2iob_pkg::id_t          s_axi_bid_o,
   output logic                      s_axi_bvalid_o,
   input  wire                       s_axi_bready_i,

   // AXI4 read channels
   input  wire axi2iob_pkg::id_t     s_axi_arid_i,
   input  wire axi2iob_pkg::addr_t   s_axi_araddr_i,
   input  wire axi2iob_pkg::len_t    s_axi_arlen_i,
   input  wire axi2iob_pkg::size_t   s_axi_arsize_i,
   input  wire                       s_axi_arvalid_i,
   output logic                      s_axi_arready_o,
   output axi2iob_pkg::id_t          s_axi_rid_o,
   output axi2iob_pkg::data_t        s_axi_rdata_o,
   output logic                      s_axi_rlast_o,
   output logic                      s_axi_rvalid_o,
   input  wire                       s_axi_rready_i,

   // IOb manager
   output logic                      iob_valid_o,
   output axi2iob_pkg::addr_t        iob_addr_o,
   output axi2iob_pkg::data_t        iob_wdata_o,
   output axi2iob_pkg::strb_t        iob_wstrb_o,
   input  wire                       iob_ready_i,
   input  wire                       iob_rvalid_i,
   input  wire axi2iob_pkg::data_t   iob_rdata_i
);

   // per-beat request channels into the bridge
   axil_if wr_bus ();
   axil_if rd_bus ();

   axi_wr_splitter i_wr_splitter (
      .clk_i           (clk_i),
      .arst_i          (arst_i),
      .s_axi_awid_i    (s_axi_awid_i),
      .s_axi_awaddr_i  (s_axi_awaddr_i),
      .s_axi_awlen_i   (s_axi_awlen_i),
      .s_axi_awsize_i  (s_axi_awsize_i),
      .s_axi_awvalid_i (s_axi_awvalid_i),
      .s_axi_awready_o (s_axi_awready_o),
      .s_axi_wdata_i   (s_axi_wdata_i),
      .s_axi_wstrb_i   (s_axi_wstrb_i),
      .s_axi_wvalid_i  (s_axi_wvalid_i),
      .s_axi_wready_o  (s_axi_wready_o),
      .s_axi_bid_o     (s_axi_bid_o),
      .s_axi_bvalid_o  (s_axi_bvalid_o),
      .s_axi_bready_i  (s_axi_bready_i),
      .wr_bus          (wr_bus.mgr)
   );

   axi_rd_splitter i_rd_splitter (
      .clk_i           (clk_i),
      .arst_i          (arst_i),
      .s_axi_arid_i    (s_axi_arid_i),
      .s_axi_araddr_i  (s_axi_araddr_i),
      .s_axi_arlen_i   (s_axi_arlen_i),
      .s_axi_arsize_i  (s_axi_arsize_i),
      .s_axi_arvalid_i (s_axi_arvalid_i),
      .s_axi_arready_o (s_axi_arready_o),
      .s_axi_rid_o     (s_axi_rid_o),
      .s_axi_rdata_o   (s_axi_rdata_o),
      .s_axi_rlast_o   (s_axi_rlast_o),
      .s_axi_rvalid_o  (s_axi_rvalid_o),
      .s_axi_rready_i  (s_axi_rready_i),
      .rd_bus          (rd_bus.mgr)
   );

   axil2iob_bridge i_bridge (
      .clk_i        (clk_i),
      .arst_i       (arst_i),
      .wr_bus       (wr_bus.sub),
      .rd_bus       (rd_bus.sub),
      .iob_valid_o  (iob_valid_o),
      .iob_addr_o   (iob_addr_o),
      .iob_wdata_o  (iob_wdata_o),
      .iob_wstrb_o  (iob_wstrb_o),
      .iob_ready_i  (iob_ready_i),
      .iob_rvalid_i (iob_rvalid_i),
      .iob_rdata_i  (iob_rdata_i)
   );

endmodule

`default_nettype wire

// File: tb/axi2iob_props.sv
/*
 * Protocol assertions for the adapter top level, attached by bind.
 * B and R stability, one outstanding IOb read, rlast only with rvalid.
 */
`timescale 1ns/1ps
`default_nettype none

module axi2iob_props (
   input wire                      clk_i,
   input wire                      arst_i,
   input wire axi2iob_pkg::id_t    bid_i,
   input wire                      bvalid_i,
   input wire                      bready_i,
   input wire axi2iob_pkg::id_t    rid_i,
   input wire axi2iob_pkg::data_t  rdata_i,
   input wire                      rlast_i,
   input wire                      rvalid_i,
   input wire                      rready_i,
   input wire                      iob_valid_i,
   input wire                      iob_ready_i,
   input wire axi2iob_pkg::strb_t  iob_wstrb_i,
   input wire                      iob_rvalid_i
);

   int unsigned fail_cnt = 0;
   logic        rd_out_q;

   // read outstanding from IOb acceptance until rvalid
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         rd_out_q <= 1'b0;
      end else if (iob_valid_i && iob_ready_i && iob_wstrb_i == '0) begin
         rd_out_q <= 1'b1;
      end else if (iob_rvalid_i) begin
         rd_out_q <= 1'b0;
      end
   end

   b_hold: assert property (@(posedge clk_i) disable iff (arst_i)
      bvalid_i && !bready_i |=> bvalid_i && $stable(bid_i))
      else begin
         $error("B response dropped or changed before bready");
         fail_cnt++;
      end

   r_hold: assert property (@(posedge clk_i) disable iff (arst_i)
      rvalid_i && !rready_i |=> rvalid_i && $stable(rid_i) && $stable(rdata_i)
                                && $stable(rlast_i))
      else begin
         $error("R beat dropped or changed before rready");
         fail_cnt++;
      end

   one_read: assert property (@(posedge clk_i) disable iff (arst_i)
      rd_out_q |-> !iob_valid_i)
      else begin
         $error("IOb access started while a read is outstanding");
         fail_cnt++;
      end

   last_valid: assert property (@(posedge clk_i) disable iff (arst_i)
      rlast_i |-> rvalid_i)
      else begin
         $error("rlast high without rvalid");
         fail_cnt++;
      end

endmodule

bind axi2iob_top axi2iob_props i_axi2iob_props (
   .clk_i        (clk_i),
   .arst_i       (arst_i),
   .bid_i        (s_axi_bid_o),
   .bvalid_i     (s_axi_bvalid_o),
   .bready_i     (s_axi_bready_i),
   .rid_i        (s_axi_rid_o),
   .rdata_i      (s_axi_rdata_o),
   .rlast_i      (s_axi_rlast_o),
   .rvalid_i     (s_axi_rvalid_o),
   .rready_i     (s_axi_rready_i),
   .iob_valid_i  (iob_valid_o),
   .iob_ready_i  (iob_ready_i),
   .iob_wstrb_i  (iob_wstrb_o),
   .iob_rvalid_i (iob_rvalid_i)
);

`default_nettype wire

// File: tb/tb_axi2iob.sv
/*
 * Testbench for the AXI4 to IOb adapter. Runs the bursts of the cases file
 * through the DUT against an IOb memory model and checks IOb writes,
 * B responses and R beats against a reference memory.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_axi2iob;
   import axi2iob_pkg::*;

   localparam int MAX_CASES = 64;
   localparam int MEM_WORDS = 1024;

   logic  clk = 1'b0;
   logic  arst;
   id_t   awid;
   addr_t awaddr;
   len_t  awlen;
   size_t awsize;
   logic  awvalid;
   logic  awready;
   data_t wdata;
   strb_t wstrb;
   logic  wvalid;
   logic  wready;
   id_t   bid;
   logic  bvalid;
   logic  bready;
   id_t   arid;
   addr_t araddr;
   len_t  arlen;
   size_t arsize;
   logic  arvalid;
   logic  arready;
   id_t   rid;
   data_t rdata;
   logic  rlast;
   logic  rvalid;
   logic  rready;
   logic  iob_valid;
   addr_t iob_addr;
   data_t iob_wdata;
   strb_t iob_wstrb;
   logic  iob_ready;
   logic  iob_rvalid;
   data_t iob_rdata;

   integer seed = 32'h109e_edb6;
   int     err_cnt = 0;
   int     num_cases = 0;
   logic   loaded = 1'b0;
   int     exp_b = 0;
   int     exp_r = 0;
   int     b_seen = 0;
   int     r_seen = 0;
   int     iob_rd_cnt = 0;
   int     wait_cnt;
   int     delay;
   int     i;
   int     fail_total;

   // burst table from the cases file
   byte    c_op   [MAX_CASES];
   id_t    c_id   [MAX_CASES];
   addr_t  c_addr [MAX_CASES];
   int     c_len  [MAX_CASES];
   int     c_size [MAX_CASES];
   strb_t  c_strb [MAX_CASES];
   data_t  c_seed [MAX_CASES];

   data_t mem     [MEM_WORDS];
   data_t ref_mem [MEM_WORDS];
   // {addr, data, strb} of each IOb write still to come
   logic [67:0] wr_exp_q [$];
   logic [67:0] exp_wr;

   always #20 clk = ~clk;

   axi2iob_top i_axi2iob_top (
      .clk_i           (clk),
      .arst_i          (arst),
      .s_axi_awid_i    (awid),
      .s_axi_awaddr_i  (awaddr),
      .s_axi_awlen_i   (awlen),
      .s_axi_awsize_i  (awsize),
      .s_axi_awvalid_i (awvalid),
      .s_axi_awready_o (awready),
      .s_axi_wdata_i   (wdata),
      .s_axi_wstrb_i   (wstrb),
      .s_axi_wvalid_i  (wvalid),
      .s_axi_wready_o  (wready),
      .s_axi_bid_o     (bid),
      .s_axi_bvalid_o  (bvalid),
      .s_axi_bready_i  (bready),
      .s_axi_arid_i    (arid),
      .s_axi_araddr_i  (araddr),
      .s_axi_arlen_i   (arlen),
      .s_axi_arsize_i  (arsize),
      .s_axi_arvalid_i (arvalid),
      .s_axi_arready_o (arready),
      .s_axi_rid_o     (rid),
      .s_axi_rdata_o   (rdata),
      .s_axi_rlast_o   (rlast),
      .s_axi_rvalid_o  (rvalid),
      .s_axi_rready_i  (rready),
      .iob_valid_o     (iob_valid),
      .iob_addr_o      (iob_addr),
      .iob_wdata_o     (iob_wdata),
      .iob_wstrb_o     (iob_wstrb),
      .iob_ready_i     (iob_ready),
      .iob_rvalid_i    (iob_rvalid),
      .iob_rdata_i     (iob_rdata)
   );

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   function automatic data_t fill_word(input addr_t a);
      return (a * 32'h9e37_79b9) ^ 32'h5a5a_c3c3;
   endfunction

   function automatic data_t merge_bytes(input data_t old_w, input data_t new_w,
                                         input strb_t strb);
      data_t res;
      int    b;
      res = old_w;
      for (b = 0; b < 4; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   function automatic logic random_bit();
      int r;
      r = $random(seed);
      return r[0];
   endfunction

   function automatic int random_delay();
      int r;
      r = $random(seed);
      return r & 3;
   endfunction

   task automatic load_cases();
      int               fd;
      int               n;
      byte              op;
      logic [8*160-1:0] skip;
      logic [31:0]      f_id;
      logic [31:0]      f_addr;
      logic [31:0]      f_len;
      logic [31:0]      f_size;
      logic [31:0]      f_strb;
      logic [31:0]      f_seed;
      fd = $fopen("tb/axi2iob_cases.txt", "r");
      if (fd == 0) begin
         $display("cannot open the cases file tb/axi2iob_cases.txt");
         err_cnt++;
         return;
      end
      while ($fscanf(fd, " %c", op) == 1) begin
         if (op == "#") begin
            n = $fgets(skip, fd);
         end else begin
            n = $fscanf(fd, "%h %h %h %d %h %h", f_id, f_addr, f_len, f_size, f_strb, f_seed);
            if (n != 6 || num_cases == MAX_CASES) begin
               $display("bad or surplus line in the cases file after case %0d", num_cases);
               err_cnt++;
            end else begin
               c_op[num_cases]   = op;
               c_id[num_cases]   = f_id;
               c_addr[num_cases] = f_addr;
               c_len[num_cases]  = f_len;
               c_size[num_cases] = f_size;
               c_strb[num_cases] = f_strb;
               c_seed[num_cases] = f_seed;
               num_cases++;
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic run_write(input int n);
      addr_t a;
      data_t d;
      int    k;
      awid    <= c_id[n];
      awaddr  <= c_addr[n];
      awlen   <= len_t'(c_len[n]);
      awsize  <= size_t'(c_size[n]);
      awvalid <= 1'b1;
      @(posedge clk);
      while (!awready) @(posedge clk);
      awvalid <= 1'b0;
      a = c_addr[n];
      for (k = 0; k <= c_len[n]; k++) begin
         d = c_seed[n] + k;
         wdata  <= d;
         wstrb  <= c_strb[n];
         wvalid <= 1'b1;
         @(posedge clk);
         while (!wready) @(posedge clk);
         // zero strobes must not reach the IOb bus
         if (c_strb[n] != '0) begin
            wr_exp_q.push_back({a, d, c_strb[n]});
         end
         ref_mem[a[11:2]] = merge_bytes(ref_mem[a[11:2]], d, c_strb[n]);
         a = a + (32'd1 << c_size[n]);
      end
      wvalid <= 1'b0;
      exp_b++;
      bready <= random_bit();
      @(posedge clk);
      while (!(bvalid && bready)) begin
         bready <= random_bit();
         @(posedge clk);
      end
      // keep taking B so that a surplus response gets counted
      bready <= 1'b1;
      check_value(bid, c_id[n], "B id");
      check_value(wr_exp_q.size(), 0, "IOb writes pending at B");
   endtask

   task automatic run_read(input int n);
      addr_t a;
      int    k;
      arid    <= c_id[n];
      araddr  <= c_addr[n];
      arlen   <= len_t'(c_len[n]);
      arsize  <= size_t'(c_size[n]);
      arvalid <= 1'b1;
      @(posedge clk);
      while (!arready) @(posedge clk);
      arvalid <= 1'b0;
      a = c_addr[n];
      for (k = 0; k <= c_len[n]; k++) begin
         rready <= random_bit();
         @(posedge clk);
         while (!(rvalid && rready)) begin
            rready <= random_bit();
            @(posedge clk);
         end
         check_value(rid, c_id[n], "R id");
         check_value(rdata, ref_mem[a[11:2]], "R data");
         check_value(rlast, k == c_len[n], "R last");
         a = a + (32'd1 << c_size[n]);
      end
      // keep taking R so that a surplus beat gets counted
      rready <= 1'b1;
      exp_r += c_len[n] + 1;
   endtask

   // IOb memory model
   // ready after 0 to 3 cycles, read data one cycle after acceptance
   always @(posedge clk) begin
      iob_rvalid <= 1'b0;
      if (arst) begin
         iob_ready <= 1'b1;
         wait_cnt  <= 0;
      end else if (iob_valid && iob_ready) begin
         if (iob_wstrb == '0) begin
            iob_rdata  <= mem[iob_addr[11:2]];
            iob_rvalid <= 1'b1;
            iob_rd_cnt++;
         end else begin
            mem[iob_addr[11:2]] = merge_bytes(mem[iob_addr[11:2]], iob_wdata, iob_wstrb);
            if (wr_exp_q.size() == 0) begin
               $display("unexpected IOb write to %h at %0t", iob_addr, $time);
               err_cnt++;
            end else begin
               exp_wr = wr_exp_q.pop_front();
               check_value(iob_addr, exp_wr[67:36], "IOb write address");
               check_value(iob_wdata, exp_wr[35:4], "IOb write data");
               check_value(iob_wstrb, exp_wr[3:0], "IOb write strobes");
            end
         end
         delay = random_delay();
         wait_cnt  <= delay;
         iob_ready <= (delay == 0);
      end else if (iob_valid) begin
         wait_cnt <= wait_cnt - 1;
         if (wait_cnt == 1) begin
            iob_ready <= 1'b1;
         end
      end
   end

   // counts every B and R handshake, catches duplicates
   always @(posedge clk) begin
      if (!arst && bvalid && bready) b_seen++;
      if (!arst && rvalid && rready) r_seen++;
   end

   initial begin
      wait (loaded);
      repeat ((num_cases > 0 ? num_cases : 1) * 300) @(posedge clk);
      $display("timeout: the run hung and did not finish within %0d cases x 300 cycles",
               num_cases);
      $display("Something failed");
      $finish;
   end

   initial begin
      arst    = 1'b1;
      awid    = '0;
      awaddr  = '0;
      awlen   = '0;
      awsize  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      arid    = '0;
      araddr  = '0;
      arlen   = '0;
      arsize  = '0;
      arvalid = 1'b0;
      rready  = 1'b1;
      iob_ready  = 1'b1;
      iob_rvalid = 1'b0;
      iob_rdata  = '0;
      wait_cnt   = 0;
      for (i = 0; i < MEM_WORDS; i++) begin
         mem[i]     = fill_word(addr_t'(i) << 2);
         ref_mem[i] = fill_word(addr_t'(i) << 2);
      end
      load_cases();
      loaded = 1'b1;
      repeat (10) @(posedge clk);
      arst <= 1'b0;
      for (i = 0; i < num_cases; i++) begin
         if (c_op[i] == "W") begin
            run_write(i);
         end else begin
            run_read(i);
         end
      end
      repeat (10) @(posedge clk);
      check_value(b_seen, exp_b, "B response count");
      check_value(r_seen, exp_r, "R beat count");
      // a zero-strobe write leaking onto IOb looks like a read there
      check_value(iob_rd_cnt, exp_r, "IOb read count");
      check_value(wr_exp_q.size(), 0, "IOb writes never seen");
      fail_total = i_axi2iob_top.i_axi2iob_props.fail_cnt;
      $display("%0d errors, %0d assertion failures", err_cnt, fail_total);
      if (err_cnt == 0 && fail_total == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/axi2iob_cases.txt
# op id addr len size strb seed: op W or R, size in decimal, the rest in hex
# strb applies to every beat of a write and is ignored for reads
W 01 00000000 00 2 f 11110000
R 02 00000000 00 2 0 00000000
W 03 00000010 07 2 f 22220000
R 04 00000010 07 2 0 00000000
R 05 00000100 03 2 0 00000000
W 06 00000200 03 2 3 33330000
R 07 00000200 03 2 0 00000000
W 08 00000010 03 2 0 44440000
R 09 00000010 07 2 0 00000000
W 0a 00000300 05 1 c 55550000
R 0b 00000300 02 2 0 00000000
W 0c 00000380 07 0 1 66660000
R 0d 00000380 01 2 0 00000000
W 0e 00000400 ff 2 f 77770000
R 0f 00000400 ff 2 0 00000000
W 10 00000800 0f 2 f 88880000
R 11 000007f0 07 2 0 00000000
W ff 00000c00 01 2 f 99990000
R ff 00000c00 01 2 0 00000000

// File: axi2iob_top.f
+incdir+common
common/axi2iob_pkg.sv
common/axil_if.sv
burst/axi_wr_splitter.sv
burst/axi_rd_splitter.sv
src/axil2iob_bridge.sv
src/axi2iob_top.sv
tb/axi2iob_props.sv
tb/tb_axi2iob.sv

// File: Bender.yml
package:
  name: axi2iob

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/axi2iob_pkg.sv
      - common/axil_if.sv
      - burst/axi_wr_splitter.sv
      - burst/axi_rd_splitter.sv
      - src/axil2iob_bridge.sv
      - src/axi2iob_top.sv
  - target: test
    files:
      - tb/axi2iob_props.sv
      - tb/tb_axi2iob.sv
